// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cu_arbiter_control
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== cu_arbiter_control.sv ====
// Top level of the vertex CU arbiter: input staging, enable register and sub-blocks
`include "pagerank_arb_macros.svh"

module cu_arbiter_control (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  logic                          read_buffer_alfull,
	input  logic                          vertex_job_valid,
	input  pagerank_arb_pkg::vertex_job_t vertex_job,
	output logic                          vertex_job_request,
	input  logic [`NUM_CU-1:0]            request_vertex_job_cu,
	output logic [`NUM_CU-1:0]            vertex_job_cu_valid,
	output pagerank_arb_pkg::vertex_job_t vertex_job_cu_out,
	input  logic [`NUM_CU-1:0]            read_cmd_cu_valid,
	input  pagerank_arb_pkg::read_cmd_t   read_cmd_cu [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]            ready_read_cmd_cu,
	input  logic                          read_command_bus_grant,
	output logic                          read_command_bus_request,
	output logic                          read_cmd_out_valid,
	output pagerank_arb_pkg::read_cmd_t   read_cmd_out,
	input  logic                          read_rsp_valid,
	input  pagerank_arb_pkg::read_rsp_t   read_rsp,
	output logic [`NUM_CU-1:0]            read_rsp_cu_valid,
	output pagerank_arb_pkg::read_rsp_t   read_rsp_cu,
	input  logic [`VERTEX_BITS-1:0]       vertex_count_cu [0:`NUM_CU-1],
	output logic [`VERTEX_BITS-1:0]       vertex_done_total
);

	import pagerank_arb_pkg::*;

	logic                    enabled;
	logic                    read_buffer_alfull_q;
	logic                    vertex_job_valid_q;
	vertex_job_t             vertex_job_q;
	logic [`NUM_CU-1:0]      request_vertex_job_cu_q;
	logic [`NUM_CU-1:0]      read_cmd_cu_valid_q;
	read_cmd_t               read_cmd_cu_q [0:`NUM_CU-1];
	logic                    read_command_bus_grant_q;
	logic                    read_rsp_valid_q;
	read_rsp_t               read_rsp_q;
	logic [`VERTEX_BITS-1:0] vertex_count_cu_q [0:`NUM_CU-1];

	////////////////////////////////////////////////////////////
	// Enable and input staging
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled                  <= 1'b0;
			read_buffer_alfull_q     <= 1'b0;
			vertex_job_valid_q       <= 1'b0;
			request_vertex_job_cu_q  <= '0;
			read_cmd_cu_valid_q      <= '0;
			read_command_bus_grant_q <= 1'b0;
			read_rsp_valid_q         <= 1'b0;
		end else begin
			enabled                  <= enabled_in;
			read_buffer_alfull_q     <= read_buffer_alfull;
			vertex_job_valid_q       <= vertex_job_valid;
			request_vertex_job_cu_q  <= request_vertex_job_cu;
			read_cmd_cu_valid_q      <= read_cmd_cu_valid;
			read_command_bus_grant_q <= read_command_bus_grant;
			read_rsp_valid_q         <= read_rsp_valid;
		end
	end

	// Payloads, qualified by their staged valids
	always_ff @(posedge clock) begin
		vertex_job_q      <= vertex_job;
		read_cmd_cu_q     <= read_cmd_cu;
		read_rsp_q        <= read_rsp;
		vertex_count_cu_q <= vertex_count_cu;
	end

	////////////////////////////////////////////////////////////
	// Sub-blocks
	////////////////////////////////////////////////////////////

	vertex_job_dispatch u_vertex_job_dispatch (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.job_valid   (vertex_job_valid_q),
		.job         (vertex_job_q),
		.request_cu  (request_vertex_job_cu_q),
		.job_request (vertex_job_request),
		.job_cu_valid(vertex_job_cu_valid),
		.job_cu      (vertex_job_cu_out)
	);

	read_command_arbiter u_read_command_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.cmd_cu_valid (read_cmd_cu_valid_q),
		.cmd_cu       (read_cmd_cu_q),
		.ready_cu     (ready_read_cmd_cu),
		.bus_alfull   (read_buffer_alfull_q),
		.bus_grant    (read_command_bus_grant_q),
		.bus_request  (read_command_bus_request),
		.cmd_out_valid(read_cmd_out_valid),
		.cmd_out      (read_cmd_out)
	);

	response_router u_response_router (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.rsp_valid   (read_rsp_valid_q),
		.rsp         (read_rsp_q),
		.rsp_cu_valid(read_rsp_cu_valid),
		.rsp_cu      (read_rsp_cu)
	);

	done_counter_reduce u_done_counter_reduce (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.count_cu(vertex_count_cu_q),
		.total   (vertex_done_total)
	);

endmodule

// ==== done_counter_reduce.sv ====
// Registered sum of the per-CU processed-vertex counters
`include "pagerank_arb_macros.svh"

module done_counter_reduce (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic [`VERTEX_BITS-1:0] count_cu [0:`NUM_CU-1],
	output logic [`VERTEX_BITS-1:0] total
);

	logic [`VERTEX_BITS-1:0] count_q [0:`NUM_CU-1];
	logic [`VERTEX_BITS-1:0] sum;

	always_ff @(posedge clock) begin
		count_q <= count_cu;
	end

	// Wraps at the counter width
	always_comb begin
		sum = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			sum = sum + count_q[i];
		end
	end

	// Frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			total <= '0;
		end else if (enabled) begin
			total <= sum;
		end
	end

endmodule

// ==== fifo_if.sv ====
// Interface between a FIFO and the block that fills and drains it
interface fifo_if #(
	parameter int WIDTH = 8
);

	logic             push;
	logic [WIDTH-1:0] data_in;
	logic             pop;
	logic [WIDTH-1:0] data_out;
	logic             full;
	logic             alfull;
	logic             empty;

	// Block that pushes and pops
	modport owner (
		output push, data_in, pop,
		input  data_out, full, alfull, empty
	);

	// The storage itself
	modport store (
		input  push, data_in, pop,
		output data_out, full, alfull, empty
	);

endinterface

// ==== pagerank_arb_macros.svh ====
// CU count, field widths, buffer depths and almost-full margin of the arbiter
`ifndef PAGERANK_ARB_MACROS_SVH
`define PAGERANK_ARB_MACROS_SVH

// Vertex compute units sharing the memory port
`define NUM_CU 4
`define CU_ID_BITS 2

// Vertex ids, degrees and counters
`define VERTEX_BITS 32

// Buffer depths, in entries
`define JOB_BUF_DEPTH 16
`define CMD_BUF_DEPTH 16

// Free entries left when almost-full rises
`define ALFULL_MARGIN 4

`define TAG_BITS 8

`endif

// ==== pagerank_arb_pkg.sv ====
// Opcode and response enums, vertex job, read command and read response structs
`include "pagerank_arb_macros.svh"

package pagerank_arb_pkg;

	// Kind of memory read a CU can issue
	typedef enum logic [1:0] {
		CMD_READ_VERTEX     = 2'd0,
		CMD_READ_EDGE_BLOCK = 2'd1
	} cmd_opcode_t;

	// Outcome reported by the memory side
	typedef enum logic [1:0] {
		RSP_DONE   = 2'd0,
		RSP_RETRY  = 2'd1,
		RSP_FAILED = 2'd2
	} rsp_code_t;

	// One vertex of work, 96 bits
	typedef struct packed {
		logic [`VERTEX_BITS-1:0] vertex_id;
		logic [`VERTEX_BITS-1:0] out_degree;
		logic [`VERTEX_BITS-1:0] edge_start;
	} vertex_job_t;

	// 76 bits with a 64-bit byte address
	typedef struct packed {
		cmd_opcode_t            opcode;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`TAG_BITS-1:0]   tag;
		logic [63:0]            address;
	} read_cmd_t;

	typedef struct packed {
		rsp_code_t              code;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`TAG_BITS-1:0]   tag;
	} read_rsp_t;

endpackage

// ==== read_command_arbiter.sv ====
// N-to-one read command arbitration into the burst buffer and memory bus request/grant
`include "pagerank_arb_macros.svh"

module read_command_arbiter (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic [`NUM_CU-1:0]          cmd_cu_valid,
	input  pagerank_arb_pkg::read_cmd_t cmd_cu [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]          ready_cu,
	input  logic                        bus_alfull,
	input  logic                        bus_grant,
	output logic                        bus_request,
	output logic                        cmd_out_valid,
	output pagerank_arb_pkg::read_cmd_t cmd_out
);

	import pagerank_arb_pkg::*;

	fifo_if #(.WIDTH($bits(read_cmd_t))) cmd_buf ();

	logic [`NUM_CU-1:0] submit;
	logic [`NUM_CU-1:0] grant;
	read_cmd_t          grant_cmd;
	logic               pop;

	////////////////////////////////////////////////////////////
	// CU side
	////////////////////////////////////////////////////////////

	// A CU just accepted still shows its old command for one cycle
	assign submit = cmd_cu_valid & ~ready_cu;

	rr_arbiter #(
		.NUM(`NUM_CU)
	) u_cmd_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enabled && !cmd_buf.alfull),
		.requests(submit),
		.grant   (grant)
	);

	// Select the granted command
	always_comb begin
		grant_cmd = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			if (grant[i]) begin
				grant_cmd = cmd_cu[i];
			end
		end
	end

	assign cmd_buf.push    = |grant;
	assign cmd_buf.data_in = grant_cmd;

	sync_fifo #(
		.WIDTH($bits(read_cmd_t)),
		.DEPTH(`CMD_BUF_DEPTH)
	) u_cmd_buf (
		.clock(clock),
		.rstn (rstn),
		.port (cmd_buf.store)
	);

	////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////

	// Late grant on an empty buffer pops nothing
	assign pop         = enabled && bus_grant && !cmd_buf.empty;
	assign cmd_buf.pop = pop;

	assign bus_request = enabled && !cmd_buf.empty && !bus_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready_cu      <= '0;
			cmd_out_valid <= 1'b0;
		end else begin
			ready_cu      <= grant;
			cmd_out_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			cmd_out <= read_cmd_t'(cmd_buf.data_out);
		end
	end

endmodule

// ==== response_router.sv ====
// Two-stage registered routing of read responses to the CU named by their id
`include "pagerank_arb_macros.svh"

module response_router (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic                        rsp_valid,
	input  pagerank_arb_pkg::read_rsp_t rsp,
	output logic [`NUM_CU-1:0]          rsp_cu_valid,
	output pagerank_arb_pkg::read_rsp_t rsp_cu
);

	import pagerank_arb_pkg::*;

	logic [`NUM_CU-1:0] sel_next;
	logic [`NUM_CU-1:0] sel_valid;
	read_rsp_t          sel_rsp;

	// Responses only come back for commands issued while enabled
	always_comb begin
		sel_next = '0;
		if (enabled && rsp_valid) begin
			sel_next[rsp.cu_id] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_valid    <= '0;
			rsp_cu_valid <= '0;
		end else begin
			sel_valid    <= sel_next;
			rsp_cu_valid <= sel_valid;
		end
	end

	// Payload follows its valid through both stages
	always_ff @(posedge clock) begin
		if (|sel_next) begin
			sel_rsp <= rsp;
		end
		if (|sel_valid) begin
			rsp_cu <= sel_rsp;
		end
	end

endmodule

// ==== rr_arbiter.sv ====
// Round-robin arbiter with a rotating priority pointer and one-hot grant
`include "pagerank_arb_macros.svh"

module rr_arbiter #(
	parameter int NUM = `NUM_CU
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enable,
	input  logic [NUM-1:0] requests,
	output logic [NUM-1:0] grant
);

	localparam int IDX_BITS = (NUM > 1) ? $clog2(NUM) : 1;

	logic [IDX_BITS-1:0] pointer;
	logic [IDX_BITS-1:0] winner;

	// Search starts at the pointer and wraps around once
	always_comb begin
		int  idx;
		logic found;
		grant  = '0;
		winner = pointer;
		found  = 1'b0;
		for (int off = 0; off < NUM; off++) begin
			idx = (int'(pointer) + off) % NUM;
			if (enable && requests[idx] && !found) begin
				grant[idx] = 1'b1;
				winner     = IDX_BITS'(idx);
				found      = 1'b1;
			end
		end
	end

	// Winner drops to lowest priority next time
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer <= '0;
		end else if (|grant) begin
			pointer <= (int'(winner) == NUM - 1) ? '0 : winner + 1'b1;
		end
	end

endmodule

// ==== sync_fifo.sv ====
// Synchronous first-word fall-through FIFO with full, almost-full and empty flags
`include "pagerank_arb_macros.svh"

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input logic   clock,
	input logic   rstn,
	fifo_if.store port
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [0:DEPTH-1];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Wrap explicitly so DEPTH need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
	endfunction

	// Push on full and pop on empty are ignored
	assign do_push = port.push && !port.full;
	assign do_pop  = port.pop && !port.empty;

	assign port.full   = (count == CNT_BITS'(DEPTH));
	assign port.alfull = (count >= CNT_BITS'(DEPTH - `ALFULL_MARGIN));
	assign port.empty  = (count == '0);

	// Head entry is visible while not empty
	assign port.data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= port.data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== tb_cu_arbiter_control.sv ====
// Testbench for the vertex CU arbiter with stimulus, reference functions, compare process and timeout
`include "pagerank_arb_macros.svh"

module tb_cu_arbiter_control;

	import pagerank_arb_pkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	// About 600 cycles of tests with a wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int N = `NUM_CU;

	logic                    clock;
	logic                    rstn;
	logic                    enabled_in;
	logic                    read_buffer_alfull;
	logic                    vertex_job_valid;
	vertex_job_t             vertex_job;
	logic                    vertex_job_request;
	logic [N-1:0]            request_vertex_job_cu;
	logic [N-1:0]            vertex_job_cu_valid;
	vertex_job_t             vertex_job_cu_out;
	logic [N-1:0]            read_cmd_cu_valid;
	read_cmd_t               read_cmd_cu [0:N-1];
	logic [N-1:0]            ready_read_cmd_cu;
	logic                    read_command_bus_grant;
	logic                    read_command_bus_request;
	logic                    read_cmd_out_valid;
	read_cmd_t               read_cmd_out;
	logic                    read_rsp_valid;
	read_rsp_t               read_rsp;
	logic [N-1:0]            read_rsp_cu_valid;
	read_rsp_t               read_rsp_cu;
	logic [`VERTEX_BITS-1:0] vertex_count_cu [0:N-1];
	logic [`VERTEX_BITS-1:0] vertex_done_total;

	integer        seed = 32'h5dc122b9;
	int            errors;
	int            checks;
	int            cycles;
	int            test_errors;
	vertex_job_t   job_q [$];
	read_cmd_t     cmd_send [0:N-1][$];
	read_cmd_t     cmd_exp [0:N-1][$];
	int            req_cnt [0:N-1];
	int            deliv_cnt [0:N-1];
	int            tag_seq [0:N-1];
	logic [N-1:0]  served;
	bit            grant_random;
	bit            fair_check;
	bit            check_pipes;
	bit            bus_req_check;
	bit            hold_check;
	// Expected router and total outputs aged one stage per clock
	logic [N-1:0]            h_route [0:2];
	read_rsp_t               h_rsp [0:2];
	logic [`VERTEX_BITS-1:0] h_total [0:2];

	cu_arbiter_control uut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Reference functions and checks
	////////////////////////////////////////////////////////////

	function automatic logic [N-1:0] expected_route(input logic valid, input read_rsp_t rsp);
		logic [N-1:0] onehot;
		onehot = '0;
		if (valid) begin
			onehot[rsp.cu_id] = 1'b1;
		end
		return onehot;
	endfunction

	function automatic logic [`VERTEX_BITS-1:0] expected_total(
		input logic [`VERTEX_BITS-1:0] counts [0:N-1]);
		logic [`VERTEX_BITS-1:0] sum;
		sum = '0;
		for (int i = 0; i < N; i++) begin
			sum = sum + counts[i];
		end
		return sum;
	endfunction

	function automatic int sum_of(input int counts [0:N-1]);
		int total;
		total = 0;
		for (int i = 0; i < N; i++) begin
			total += counts[i];
		end
		return total;
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (expected === actual) else begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Advance one cycle and update CU command drivers, grant and pulses
	task automatic step();
		logic [N-1:0] others;
		@(negedge clock);
		for (int i = 0; i < N; i++) begin
			if (ready_read_cmd_cu[i] && read_cmd_cu_valid[i]) begin
				if (fair_check) begin
					others    = read_cmd_cu_valid & ~served;
					others[i] = 1'b0;
					check_true(!(served[i] && others != '0),
						"CU accepted twice while another CU was still waiting");
					served[i] = 1'b1;
					if ((read_cmd_cu_valid & ~served) == '0) begin
						served = '0;
					end
				end
				void'(cmd_send[i].pop_front());
			end
		end
		for (int i = 0; i < N; i++) begin
			read_cmd_cu_valid[i] = (cmd_send[i].size() > 0);
			if (cmd_send[i].size() > 0) begin
				read_cmd_cu[i] = cmd_send[i][0];
			end
		end
		read_command_bus_grant = grant_random ? $random(seed) & 1 : 1'b0;
		vertex_job_valid       = 1'b0;
		request_vertex_job_cu  = '0;
		read_rsp_valid         = 1'b0;
	endtask

	task automatic push_job();
		vertex_job_valid      = 1'b1;
		vertex_job.vertex_id  = $random(seed);
		vertex_job.out_degree = $random(seed);
		vertex_job.edge_start = $random(seed);
		job_q.push_back(vertex_job);
	endtask

	task automatic load_commands(input int per_cu);
		read_cmd_t cmd;
		for (int i = 0; i < N; i++) begin
			for (int s = 0; s < per_cu; s++) begin
				cmd.opcode  = tag_seq[i][0] ? CMD_READ_EDGE_BLOCK : CMD_READ_VERTEX;
				cmd.cu_id   = i[`CU_ID_BITS-1:0];
				cmd.tag     = {i[1:0], tag_seq[i][5:0]};
				cmd.address = {$random(seed), $random(seed)};
				tag_seq[i]++;
				cmd_send[i].push_back(cmd);
				cmd_exp[i].push_back(cmd);
			end
		end
	endtask

	function automatic bit commands_drained();
		for (int i = 0; i < N; i++) begin
			if (cmd_exp[i].size() > 0 || cmd_send[i].size() > 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		for (int s = 2; s > 0; s--) begin
			h_route[s] = h_route[s-1];
			h_rsp[s]   = h_rsp[s-1];
			h_total[s] = h_total[s-1];
		end
		h_route[0] = expected_route(read_rsp_valid, read_rsp);
		h_rsp[0]   = read_rsp;
		h_total[0] = expected_total(vertex_count_cu);
	end

	always @(negedge clock) begin
		int cu;
		if (rstn) begin
			if (check_pipes) begin
				check_value("read_rsp_cu_valid", h_route[2], read_rsp_cu_valid);
				if (h_route[2] != '0) begin
					check_value("read_rsp_cu", h_rsp[2], read_rsp_cu);
				end
				check_value("vertex_done_total", h_total[2], vertex_done_total);
			end
			if (vertex_job_cu_valid != '0) begin
				cu = 0;
				for (int i = 0; i < N; i++) begin
					if (vertex_job_cu_valid[i]) begin
						cu = i;
					end
				end
				check_true($onehot(vertex_job_cu_valid), "job delivered to several CUs at once");
				check_true(deliv_cnt[cu] < req_cnt[cu],
					"job delivered to a CU without an outstanding request");
				deliv_cnt[cu]++;
				if (job_q.size() == 0) begin
					check_true(1'b0, "job delivered that was never pushed");
				end else begin
					check_value("vertex_job_cu_out", job_q.pop_front(), vertex_job_cu_out);
				end
			end
			if (read_cmd_out_valid) begin
				cu = int'(read_cmd_out.cu_id);
				if (cmd_exp[cu].size() == 0) begin
					check_true(1'b0, "command issued on the bus that no CU submitted");
				end else begin
					check_value("read_cmd_out", cmd_exp[cu].pop_front(), read_cmd_out);
				end
			end
			if (bus_req_check) begin
				check_value("read_command_bus_request", 0, read_command_bus_request);
			end
			if (hold_check) begin
				check_value("ready_read_cmd_cu", 0, ready_read_cmd_cu);
				check_value("vertex_job_cu_valid", 0, vertex_job_cu_valid);
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int pushed;
		int req_total;
		int cu;
		bit saw_low;
		rstn = 1'b0;
		enabled_in = 1'b1;
		read_buffer_alfull = 1'b0;
		vertex_job_valid = 1'b0;
		vertex_job = '0;
		request_vertex_job_cu = '0;
		read_cmd_cu_valid = '0;
		read_command_bus_grant = 1'b0;
		read_rsp_valid = 1'b0;
		read_rsp = '0;
		for (int i = 0; i < N; i++) begin
			read_cmd_cu[i] = '0;
			vertex_count_cu[i] = '0;
			req_cnt[i] = 0;
			deliv_cnt[i] = 0;
			tag_seq[i] = 0;
		end
		served = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// Reset values
		step();
		step();
		check_value("vertex_job_cu_valid", 0, vertex_job_cu_valid);
		check_value("ready_read_cmd_cu", 0, ready_read_cmd_cu);
		check_value("read_command_bus_request", 0, read_command_bus_request);
		check_value("read_cmd_out_valid", 0, read_cmd_out_valid);
		check_value("read_rsp_cu_valid", 0, read_rsp_cu_valid);
		check_value("vertex_done_total", 0, vertex_done_total);
		check_value("vertex_job_request", 1, vertex_job_request);
		end_test("reset");

		check_pipes = 1'b1;
		for (int k = 0; k < 200; k++) begin
			step();
			read_rsp_valid = 1'b1;
			read_rsp.code  = rsp_code_t'({$random(seed)} % 3);
			read_rsp.cu_id = $random(seed);
			read_rsp.tag   = $random(seed);
		end
		repeat (4) step();
		check_pipes = 1'b0;
		end_test("response routing");

		// Fill with no requests and drain with random requests
		pushed  = 0;
		saw_low = 1'b0;
		for (int k = 0; k < 24; k++) begin
			step();
			if (vertex_job_request) begin
				push_job();
				pushed++;
			end else begin
				saw_low = 1'b1;
			end
		end
		check_true(saw_low, "vertex_job_request never fell while the job buffer filled");
		check_true(pushed <= `JOB_BUF_DEPTH, "more jobs pushed than the job buffer holds");
		req_total = 0;
		while (sum_of(deliv_cnt) < 40) begin
			step();
			if (vertex_job_request && pushed < 40) begin
				push_job();
				pushed++;
			end
			cu = {$random(seed)} % N;
			if (req_total < 40 && ($random(seed) & 1) && req_cnt[cu] - deliv_cnt[cu] < 12) begin
				request_vertex_job_cu[cu] = 1'b1;
				req_cnt[cu]++;
				req_total++;
			end
		end
		repeat (5) step();
		for (int i = 0; i < N; i++) begin
			check_value("deliveries per CU", req_cnt[i], deliv_cnt[i]);
		end
		end_test("vertex dispatch");

		fair_check   = 1'b1;
		grant_random = 1'b1;
		load_commands(8);
		while (!commands_drained()) begin
			step();
		end
		fair_check   = 1'b0;
		grant_random = 1'b0;
		end_test("read commands");

		// Bus back-pressure and then the enable held low
		read_buffer_alfull = 1'b1;
		bus_req_check = 1'b1;
		load_commands(2);
		repeat (30) step();
		enabled_in = 1'b0;
		repeat (3) step();
		hold_check = 1'b1;
		load_commands(1);
		for (int i = 0; i < N; i++) begin
			step();
			push_job();
			request_vertex_job_cu[i] = 1'b1;
			req_cnt[i]++;
		end
		repeat (20) step();
		hold_check = 1'b0;
		enabled_in = 1'b1;
		read_buffer_alfull = 1'b0;
		bus_req_check = 1'b0;
		repeat (2) step();
		// Held commands now ask for the bus
		check_value("read_command_bus_request", 1, read_command_bus_request);
		grant_random = 1'b1;
		while (!commands_drained() || sum_of(deliv_cnt) < sum_of(req_cnt)) begin
			step();
		end
		grant_random = 1'b0;
		repeat (4) step();
		end_test("back-pressure and enable");

		check_pipes = 1'b1;
		for (int k = 0; k < 30; k++) begin
			step();
			for (int i = 0; i < N; i++) begin
				vertex_count_cu[i] = $random(seed);
			end
		end
		repeat (4) step();
		check_pipes = 1'b0;
		end_test("done count");

		$display("all tests finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== vertex_job_dispatch.sv ====
// Vertex job buffer, per-CU pending requests and one-to-N round-robin delivery
`include "pagerank_arb_macros.svh"

module vertex_job_dispatch (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  logic                          job_valid,
	input  pagerank_arb_pkg::vertex_job_t job,
	input  logic [`NUM_CU-1:0]            request_cu,
	output logic                          job_request,
	output logic [`NUM_CU-1:0]            job_cu_valid,
	output pagerank_arb_pkg::vertex_job_t job_cu
);

	import pagerank_arb_pkg::*;

	// Outstanding requests one CU may stack up
	localparam int PEND_BITS = 4;

	fifo_if #(.WIDTH($bits(vertex_job_t))) job_buf ();

	logic [PEND_BITS-1:0] pending [0:`NUM_CU-1];
	logic [`NUM_CU-1:0]   pending_any;
	logic [`NUM_CU-1:0]   grant;

	////////////////////////////////////////////////////////////
	// Job buffer
	////////////////////////////////////////////////////////////

	// Host pushes are taken even while disabled
	assign job_buf.push    = job_valid;
	assign job_buf.data_in = job;
	assign job_buf.pop     = |grant;

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(`JOB_BUF_DEPTH)
	) u_job_buf (
		.clock(clock),
		.rstn (rstn),
		.port (job_buf.store)
	);

	////////////////////////////////////////////////////////////
	// Pending requests and arbitration
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `NUM_CU; g++) begin : gen_pending
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				pending[g] <= '0;
			end else if (request_cu[g] && !grant[g] && pending[g] != '1) begin
				pending[g] <= pending[g] + 1'b1;
			end else if (!request_cu[g] && grant[g]) begin
				pending[g] <= pending[g] - 1'b1;
			end
		end
		assign pending_any[g] = (pending[g] != '0);
	end

	// One CU per cycle and only with a job at the head
	rr_arbiter #(
		.NUM(`NUM_CU)
	) u_job_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enabled && !job_buf.empty),
		.requests(pending_any),
		.grant   (grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request  <= 1'b0;
			job_cu_valid <= '0;
		end else begin
			job_request  <= !job_buf.alfull;
			job_cu_valid <= grant;
		end
	end

	always_ff @(posedge clock) begin
		if (|grant) begin
			job_cu <= vertex_job_t'(job_buf.data_out);
		end
	end

endmodule

// ==== vlog.f ====
+incdir+.
pagerank_arb_pkg.sv
fifo_if.sv
sync_fifo.sv
rr_arbiter.sv
vertex_job_dispatch.sv
read_command_arbiter.sv
response_router.sv
done_counter_reduce.sv
cu_arbiter_control.sv
tb_cu_arbiter_control.sv
